// File: axi_pkg.sv
package axi_pkg;

  localparam int LEN_BITS = 8;

  // burst length in beats minus one, as on arlen
  typedef logic [LEN_BITS-1:0] axi_len_t;

  localparam axi_len_t LEN_LINE = 8'd3;    // four beats fill one line
  localparam axi_len_t LEN_SINGLE = 8'd0;  // uncached word

endpackage

// File: build.f
fetch_pkg.sv
axi_pkg.sv
fetch_ifs.sv
icache_array.sv
refill_master.sv
fetch_unit.sv
fetch_top.sv
tb_axi_memory.sv
tb_fetch_top.sv

// File: fetch_ifs.sv
interface refill_if;
  logic req_valid;
  fetch_pkg::addr_t req_addr;
  logic req_uncached;
  logic req_ready;
  logic beat_valid;
  fetch_pkg::inst_t beat_data;
  logic beat_last;

  modport requester(output req_valid, req_addr, req_uncached,
                    input req_ready, beat_valid, beat_data, beat_last);
  modport server(input req_valid, req_addr, req_uncached,
                 output req_ready, beat_valid, beat_data, beat_last);
endinterface

interface cache_if;
  fetch_pkg::addr_t lookup_addr;
  logic hit;
  fetch_pkg::inst_t hit_word;
  logic fill_valid;
  fetch_pkg::inst_t fill_data;
  logic fill_last;
  fetch_pkg::addr_t fill_addr;

  modport client(output lookup_addr, fill_valid, fill_data, fill_last, fill_addr,
                 input hit, hit_word);
  modport store(input lookup_addr, fill_valid, fill_data, fill_last, fill_addr,
                output hit, hit_word);
endinterface

// File: fetch_pkg.sv
package fetch_pkg;

  localparam int ADDR_BITS = 32;
  localparam int WORD_BITS = 32;
  localparam int LINE_WORDS = 4;
  localparam int LINES = 4;
  localparam int BYTE_BITS = 2;        // byte offset inside a word
  localparam int WORD_SEL_BITS = 2;
  localparam int INDEX_BITS = 2;
  localparam int OFFSET_BITS = BYTE_BITS + WORD_SEL_BITS;
  localparam int TAG_BITS = ADDR_BITS - OFFSET_BITS - INDEX_BITS;
  localparam int LINE_BITS = LINE_WORDS * WORD_BITS;
  localparam int INST_BYTES = 4;

  typedef logic [ADDR_BITS-1:0] addr_t;
  typedef logic [WORD_BITS-1:0] inst_t;
  typedef logic [TAG_BITS-1:0] tag_t;
  typedef logic [INDEX_BITS-1:0] index_t;
  typedef logic [WORD_SEL_BITS-1:0] word_sel_t;
  typedef logic [LINE_BITS-1:0] line_t;  // word 0 in the low bits

  localparam addr_t RESET_PC = 32'h3000_0000;
  localparam logic [7:0] UNCACHED_PREFIX = 8'h0f;  // matched against addr[31:24]

  function automatic tag_t tag_of(addr_t addr);
    return addr[ADDR_BITS-1 -: TAG_BITS];
  endfunction

  function automatic index_t index_of(addr_t addr);
    return addr[OFFSET_BITS +: INDEX_BITS];
  endfunction

  function automatic word_sel_t word_of(addr_t addr);
    return addr[BYTE_BITS +: WORD_SEL_BITS];
  endfunction

  function automatic logic is_uncached(addr_t addr);
    return addr[ADDR_BITS-1 -: 8] == UNCACHED_PREFIX;
  endfunction

  function automatic addr_t line_base(addr_t addr);
    return {addr[ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
  endfunction

endpackage

// File: fetch_stimulus.txt
# op address count misses, misses are AR handshakes from the redirect to the last accept
# R redirect and fetch, B same with a throttled decoder, F flush (address and count unused)
R 30000000 16 4
R 30000000 1 2
R 30000000 16 0
F 00000000 0 0
R 30000000 16 5
R 0f000100 4 5
B 30000000 16 2
R 30000100 8 3
B 30000024 6 2
F 00000000 0 0
R 30000020 8 2
R 0f000200 3 4
R 30000000 4 2
B 30000010 16 2

// File: fetch_top.sv
module fetch_top (
  input  logic clock,
  input  logic reset,
  input  logic redirect,
  input  fetch_pkg::addr_t redirect_pc,
  input  logic flush,
  output logic inst_valid,
  input  logic inst_ready,
  output fetch_pkg::inst_t inst,
  output fetch_pkg::addr_t inst_pc,
  output fetch_pkg::addr_t araddr,
  output axi_pkg::axi_len_t arlen,
  output logic arvalid,
  input  logic arready,
  input  fetch_pkg::inst_t rdata,
  input  logic rvalid,
  output logic rready,
  input  logic rlast
);

  refill_if refill_bus ();
  cache_if cache_bus ();

  fetch_unit fetch0 (
    .clock       (clock),
    .reset       (reset),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .inst_valid  (inst_valid),
    .inst_ready  (inst_ready),
    .inst        (inst),
    .inst_pc     (inst_pc),
    .refill      (refill_bus.requester),
    .cache       (cache_bus.client)
  );

  icache_array icache0 (
    .clock (clock),
    .reset (reset),
    .flush (flush),
    .cache (cache_bus.store)
  );

  refill_master refill0 (
    .clock   (clock),
    .reset   (reset),
    .refill  (refill_bus.server),
    .araddr  (araddr),
    .arlen   (arlen),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rvalid  (rvalid),
    .rready  (rready),
    .rlast   (rlast)
  );

endmodule

// File: fetch_unit.sv
module fetch_unit (
  input  logic clock,
  input  logic reset,
  input  logic redirect,
  input  fetch_pkg::addr_t redirect_pc,
  output logic inst_valid,
  input  logic inst_ready,
  output fetch_pkg::inst_t inst,
  output fetch_pkg::addr_t inst_pc,
  refill_if.requester refill,
  cache_if.client cache
);

  typedef enum logic [1:0] {
    lookup,
    request,
    wait_beats,
    discard
  } state_t;

  state_t state;
  fetch_pkg::addr_t pc;
  fetch_pkg::addr_t miss_addr;
  logic miss_uncached;
  fetch_pkg::word_sel_t beat_count;
  fetch_pkg::inst_t miss_word;

  logic out_free;
  logic req_fire;
  logic last_beat;
  logic busy;
  logic take_beat;
  logic hit_go;
  logic miss_go;

  assign out_free = !inst_valid || inst_ready;
  assign req_fire = refill.req_valid && refill.req_ready;
  assign last_beat = refill.beat_valid && refill.beat_last;
  assign busy = state == wait_beats || state == discard || req_fire;  // refill owed beats
  assign take_beat = miss_uncached || beat_count == fetch_pkg::word_of(miss_addr);
  assign hit_go = state == lookup && out_free && cache.hit;
  assign miss_go = state == lookup && out_free && !cache.hit;

  assign refill.req_valid = state == request;
  assign refill.req_addr = miss_addr;
  assign refill.req_uncached = miss_uncached;

  assign cache.lookup_addr = pc;
  assign cache.fill_valid = refill.beat_valid && !miss_uncached;
  assign cache.fill_data = refill.beat_data;
  assign cache.fill_last = refill.beat_last;
  assign cache.fill_addr = miss_addr;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= lookup;
      pc <= fetch_pkg::RESET_PC;
      inst_valid <= 1'b0;
    end else if (redirect) begin
      pc <= redirect_pc;
      inst_valid <= 1'b0;
      // a burst already on the bus has to drain first
      state <= (busy && !last_beat) ? discard : lookup;
    end else begin
      case (state)
        lookup: begin
          if (out_free) begin
            inst_valid <= cache.hit;
            if (cache.hit) begin
              pc <= pc + fetch_pkg::addr_t'(fetch_pkg::INST_BYTES);
            end else begin
              state <= request;
            end
          end
        end
        request: begin
          if (req_fire) begin
            state <= wait_beats;
          end
        end
        wait_beats: begin
          if (last_beat) begin
            state <= lookup;
            inst_valid <= 1'b1;
            pc <= miss_addr + fetch_pkg::addr_t'(fetch_pkg::INST_BYTES);
          end
        end
        discard: begin
          if (last_beat) begin
            state <= lookup;
          end
        end
        default: state <= lookup;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (miss_go) begin
      miss_addr <= pc;
      miss_uncached <= fetch_pkg::is_uncached(pc);
    end
    if (req_fire) begin
      beat_count <= '0;
    end else if (refill.beat_valid) begin
      beat_count <= beat_count + 2'd1;
    end
    if (refill.beat_valid && take_beat) begin
      miss_word <= refill.beat_data;
    end
    if (hit_go) begin
      inst <= cache.hit_word;
      inst_pc <= pc;
    end else if (state == wait_beats && last_beat) begin
      inst <= take_beat ? refill.beat_data : miss_word;
      inst_pc <= miss_addr;
    end
  end

  // decoder sees a stable word until it takes it
  a_out_stable: assert property (@(posedge clock) disable iff (reset)
    inst_valid && !inst_ready && !redirect |=> inst_valid && $stable(inst) && $stable(inst_pc))
    else $error("inst or inst_pc changed while stalled");

endmodule

// File: icache_array.sv
module icache_array (
  input logic clock,
  input logic reset,
  input logic flush,
  cache_if.store cache
);

  fetch_pkg::tag_t tags [fetch_pkg::LINES];
  fetch_pkg::line_t lines [fetch_pkg::LINES];
  logic [fetch_pkg::LINES-1:0] valid;

  fetch_pkg::index_t lookup_index;
  fetch_pkg::word_sel_t lookup_sel;
  fetch_pkg::index_t fill_index;
  fetch_pkg::line_t lookup_line;

  logic fill_active;  // a line is part way in
  logic fill_cancel;  // flush seen during this fill
  logic [2:0] fill_count;

  assign lookup_index = fetch_pkg::index_of(cache.lookup_addr);
  assign lookup_sel = fetch_pkg::word_of(cache.lookup_addr);
  assign fill_index = fetch_pkg::index_of(cache.fill_addr);
  assign lookup_line = lines[lookup_index];

  assign cache.hit = valid[lookup_index]
                     && tags[lookup_index] == fetch_pkg::tag_of(cache.lookup_addr)
                     && !fetch_pkg::is_uncached(cache.lookup_addr);
  assign cache.hit_word = lookup_line[lookup_sel * fetch_pkg::WORD_BITS +: fetch_pkg::WORD_BITS];

  always_ff @(posedge clock) begin
    if (reset) begin
      valid <= '0;
      fill_active <= 1'b0;
      fill_cancel <= 1'b0;
      fill_count <= '0;
    end else begin
      if (cache.fill_valid) begin
        fill_active <= !cache.fill_last;
        fill_count <= cache.fill_last ? 3'd0 : fill_count + 3'd1;
        // line is invalid while it is being shifted in
        valid[fill_index] <= cache.fill_last && !fill_cancel;
      end
      if (cache.fill_valid && cache.fill_last) begin
        fill_cancel <= 1'b0;
      end else if (flush && (fill_active || cache.fill_valid)) begin
        fill_cancel <= 1'b1;
      end
      if (flush) begin
        valid <= '0;  // wins over a same-cycle tag write
      end
    end
  end

  always_ff @(posedge clock) begin
    if (cache.fill_valid) begin
      lines[fill_index] <= {cache.fill_data,
                            lines[fill_index][fetch_pkg::LINE_BITS-1:fetch_pkg::WORD_BITS]};
      if (cache.fill_last) begin
        tags[fill_index] <= fetch_pkg::tag_of(cache.fill_addr);
      end
    end
  end

  // the refill burst never runs past one line
  a_fill_burst: assert property (@(posedge clock) disable iff (reset)
    cache.fill_valid |-> fill_count < 3'(fetch_pkg::LINE_WORDS))
    else $error("fill burst longer than %0d beats", fetch_pkg::LINE_WORDS);

endmodule

// File: refill_master.sv
module refill_master (
  input  logic clock,
  input  logic reset,
  refill_if.server refill,
  output fetch_pkg::addr_t araddr,
  output axi_pkg::axi_len_t arlen,
  output logic arvalid,
  input  logic arready,
  input  fetch_pkg::inst_t rdata,
  input  logic rvalid,
  output logic rready,
  input  logic rlast
);

  typedef enum logic [1:0] {
    idle,
    addr,
    data
  } state_t;

  state_t state;
  logic req_fire;

  assign req_fire = refill.req_valid && refill.req_ready;

  assign refill.req_ready = state == idle;
  assign arvalid = state == addr;
  assign rready = state == data;

  // beats pass straight through as the fetch unit never stalls them
  assign refill.beat_valid = rvalid && rready;
  assign refill.beat_data = rdata;
  assign refill.beat_last = rlast;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= idle;
    end else begin
      case (state)
        idle: begin
          if (req_fire) begin
            state <= addr;
          end
        end
        addr: begin
          if (arready) begin
            state <= data;
          end
        end
        data: begin
          if (rvalid && rlast) begin
            state <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (req_fire) begin
      if (refill.req_uncached) begin
        araddr <= refill.req_addr;  // single word
        arlen <= axi_pkg::LEN_SINGLE;
      end else begin
        araddr <= fetch_pkg::line_base(refill.req_addr);
        arlen <= axi_pkg::LEN_LINE;
      end
    end
  end

  // AXI rule on the address channel
  a_ar_hold: assert property (@(posedge clock) disable iff (reset)
    arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen))
    else $error("araddr changed or arvalid dropped before arready");

endmodule

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert --top-module tb_fetch_top -f build.f \
  && ./obj_dir/Vtb_fetch_top | tee /dev/stderr | grep "TEST PASSED" > /dev/null \
  || { echo "simulation did not pass" >&2; exit 1; }

// File: tb_axi_memory.sv
module tb_axi_memory (
  input  logic clock,
  input  logic reset,
  input  fetch_pkg::addr_t araddr,
  input  axi_pkg::axi_len_t arlen,
  input  logic arvalid,
  output logic arready,
  output fetch_pkg::inst_t rdata,
  output logic rvalid,
  input  logic rready,
  output logic rlast
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [31:0] stall_state;

  function automatic logic [31:0] lcg_step(logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic fetch_pkg::inst_t word_at(fetch_pkg::addr_t addr);
    return addr ^ 32'ha5a5_0000;
  endfunction

  task automatic random_stall();
    stall_state = lcg_step(stall_state);
    repeat (stall_state[31:30]) @(negedge clock);  // 0 to 3 idle cycles
  endtask

  task automatic serve_burst();
    fetch_pkg::addr_t base;
    axi_pkg::axi_len_t len;
    int beat;
    random_stall();
    arready = 1'b1;
    base = araddr;
    len = arlen;
    @(negedge clock);
    arready = 1'b0;
    for (beat = 0; beat <= int'(len); beat++) begin
      random_stall();
      while (!rready) @(negedge clock);
      rvalid = 1'b1;
      rdata = word_at(base + fetch_pkg::addr_t'(beat * 4));
      rlast = beat == int'(len);
      @(negedge clock);
      rvalid = 1'b0;
      rlast = 1'b0;
    end
  endtask

  initial begin
    stall_state = 32'h92bf4b55;
    arready = 1'b0;
    rvalid = 1'b0;
    rlast = 1'b0;
    rdata = '0;
    forever begin
      @(negedge clock);
      if (!reset && arvalid) begin
        serve_burst();
      end
    end
  end

endmodule

// File: tb_fetch_top.sv
module tb_fetch_top;
  timeunit 1ns;
  timeprecision 1ps;

  logic clock;
  logic reset;
  logic redirect;
  fetch_pkg::addr_t redirect_pc;
  logic flush;
  logic inst_valid;
  logic inst_ready;
  fetch_pkg::inst_t inst;
  fetch_pkg::addr_t inst_pc;
  fetch_pkg::addr_t araddr;
  axi_pkg::axi_len_t arlen;
  logic arvalid;
  logic arready;
  fetch_pkg::inst_t rdata;
  logic rvalid;
  logic rready;
  logic rlast;

  logic [7:0] op_code [64];
  fetch_pkg::addr_t op_addr [64];
  int op_count [64];
  int op_miss [64];
  int n_ops;
  int op_total;
  int misses;
  int check_errors;
  int ar_errors = 0;
  int ar_count = 0;
  int cycles = 0;
  int cycle_limit = 1000;
  fetch_pkg::addr_t last_uncached_addr = '0;
  logic burst_open = 1'b0;
  logic [31:0] ready_state;

  fetch_top dut0 (.*);
  tb_axi_memory mem0 (.*);

  always #50 clock = ~clock;

  function automatic logic [31:0] lcg_step(logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic fetch_pkg::inst_t expected_word(fetch_pkg::addr_t addr);
    return addr ^ 32'ha5a5_0000;
  endfunction

  // AR handshakes and their burst shape
  always @(posedge clock) begin
    if (!reset && arvalid && arready) begin
      ar_count = ar_count + 1;
      if (araddr[31:24] == 8'h0f) begin
        last_uncached_addr = araddr;
        assert (arlen == 8'd0) else begin
          ar_errors++;
          $display("FAIL arlen got %h expected %h", arlen, 8'd0);
        end
      end else begin
        assert (arlen == 8'd3) else begin
          ar_errors++;
          $display("FAIL arlen got %h expected %h", arlen, 8'd3);
        end
        assert (araddr[3:0] == 4'h0) else begin
          ar_errors++;
          $display("FAIL araddr got %h expected %h", araddr, {araddr[31:4], 4'h0});
        end
      end
    end
  end

  // rready is high from the cycle after the AR handshake through the rlast beat
  always @(posedge clock) begin
    if (!reset) begin
      assert (rready == burst_open) else begin
        ar_errors++;
        $display("FAIL rready got %h expected %h", rready, burst_open);
      end
      if (arvalid && arready) begin
        burst_open = 1'b1;
      end else if (rvalid && rready && rlast) begin
        burst_open = 1'b0;
      end
    end
  end

  always @(posedge clock) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("timeout, the fetch stage stopped delivering after %0d cycles", cycles);
      $display("error count %0d", check_errors + ar_errors);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic skip_line(input int fd);
    int c;
    c = 0;
    while (c >= 0 && c != 10) c = $fgetc(fd);
  endtask

  task automatic load_stimulus();
    int fd;
    int c;
    int n;
    logic [7:0] ch;
    fetch_pkg::addr_t a;
    int cnt;
    int miss;
    n_ops = 0;
    op_total = 0;
    fd = $fopen("fetch_stimulus.txt", "r");
    if (fd == 0) begin
      check_errors++;
      $display("cannot open fetch_stimulus.txt");
    end else begin
      c = $fgetc(fd);
      while (c >= 0) begin
        ch = c[7:0];
        if (ch == "#") begin
          skip_line(fd);
        end else if (ch == "R" || ch == "B" || ch == "F") begin
          n = $fscanf(fd, "%h %d %d", a, cnt, miss);
          if (n != 3) begin
            check_errors++;
            $display("stimulus operation %0d is missing a field", n_ops);
          end
          op_code[n_ops] = ch;
          op_addr[n_ops] = a;
          op_count[n_ops] = cnt;
          op_miss[n_ops] = miss;
          n_ops++;
          op_total += cnt;
        end else if (ch != " " && ch != "\n" && ch != "\r" && ch != "\t") begin
          check_errors++;
          $display("stimulus file holds an unknown operation %c", ch);
          skip_line(fd);
        end
        c = $fgetc(fd);
      end
      $fclose(fd);
    end
  endtask

  // redirects and accepts count instructions and returns on the negedge after the last one
  task automatic fetch_path(input fetch_pkg::addr_t target, input int count,
                            input logic throttle, output int ar_seen);
    int accepted;
    int ar_start;
    fetch_pkg::addr_t expect_pc;
    logic ready;
    logic held;
    fetch_pkg::inst_t held_inst;
    fetch_pkg::addr_t held_pc;
    ar_start = ar_count;
    redirect = 1'b1;
    redirect_pc = target;
    inst_ready = 1'b0;  // nothing from the old path is taken
    @(negedge clock);
    redirect = 1'b0;
    accepted = 0;
    expect_pc = target;
    held = 1'b0;
    while (accepted < count) begin
      if (throttle) begin
        ready_state = lcg_step(ready_state);
        ready = ready_state[31:30] != 2'b00;
      end else begin
        ready = 1'b1;
      end
      if (held) begin
        assert (inst_valid) else begin
          check_errors++;
          $display("inst_valid dropped while the decoder was stalled");
        end
        assert (inst == held_inst) else begin
          check_errors++;
          $display("FAIL inst got %h expected %h", inst, held_inst);
        end
        assert (inst_pc == held_pc) else begin
          check_errors++;
          $display("FAIL inst_pc got %h expected %h", inst_pc, held_pc);
        end
      end
      inst_ready = ready;
      if (inst_valid && ready) begin  // transfer on the coming posedge
        assert (inst_pc == expect_pc) else begin
          check_errors++;
          $display("FAIL inst_pc got %h expected %h", inst_pc, expect_pc);
        end
        assert (inst == expected_word(expect_pc)) else begin
          check_errors++;
          $display("FAIL inst got %h expected %h", inst, expected_word(expect_pc));
        end
        if (inst_pc[31:24] == 8'h0f) begin
          assert (last_uncached_addr == inst_pc) else begin
            check_errors++;
            $display("FAIL araddr got %h expected %h", last_uncached_addr, inst_pc);
          end
        end
        accepted++;
        expect_pc = expect_pc + 32'd4;
        held = 1'b0;
      end else begin
        held = inst_valid;
        held_inst = inst;
        held_pc = inst_pc;
      end
      @(negedge clock);
    end
    inst_ready = 1'b0;
    ar_seen = ar_count - ar_start;
  endtask

  task automatic flush_cache(output int ar_seen);
    int ar_start;
    ar_start = ar_count;
    flush = 1'b1;
    inst_ready = 1'b0;
    @(negedge clock);
    flush = 1'b0;
    ar_seen = ar_count - ar_start;
  endtask

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    redirect = 1'b0;
    redirect_pc = '0;
    flush = 1'b0;
    inst_ready = 1'b0;
    check_errors = 0;
    ready_state = 32'h92bf4b55;
    load_stimulus();
    cycle_limit = 40 * op_total + 1000;
    repeat (16) @(negedge clock);
    reset = 1'b0;
    for (int i = 0; i < n_ops; i++) begin
      if (op_code[i] == "F") begin
        flush_cache(misses);
      end else begin
        fetch_path(op_addr[i], op_count[i], op_code[i] == "B", misses);
      end
      assert (misses == op_miss[i]) else begin
        check_errors++;
        $display("FAIL ar_handshakes in operation %0d got %h expected %h", i, misses, op_miss[i]);
      end
    end
    $display("error count %0d (%0d fetch, %0d AXI)", check_errors + ar_errors,
             check_errors, ar_errors);
    if (check_errors + ar_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
